//--- tag_store_top.f
tag_store_pkg.sv
payload_ram.sv
valid_tag_ram.sv
wb_bank_decoder.sv
bank_read_collector.sv
tag_store_top.sv
tb_tag_store.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing \
    --top-module tb_tag_store \
    --x-assign 0 --x-initial 0 \
    -f tag_store_top.f \
    -o Vtb_tag_store

./obj_dir/Vtb_tag_store > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "^Testbench passed$" "$LOG"; then
    exit 0
fi
echo "simulation did not pass, see $LOG"
exit 1

//--- tag_store_golden.txt
# op addr wdata expect, every field after op in hex
# op: W write, R read, C consume read, F flush, S status read; expect unused for W and F
S 800 00000000 00000000
R 000 00000000 00000000
R 045 00000000 00000000
R 0A3 00000000 00000000
R 0FF 00000000 00000000
C 405 00000000 00000000
W 005 80123456 00000000
W 045 80ABCDEF 00000000
W 085 80555AAA 00000000
W 0C5 FF0F0F0F 00000000
R 005 00000000 80123456
R 045 00000000 80ABCDEF
R 085 00000000 80555AAA
R 0C5 00000000 800F0F0F
W 03F 80FFFFFF 00000000
R 03F 00000000 80FFFFFF
R 006 00000000 00000000
W 045 80777777 00000000
R 005 00000000 80123456
R 045 00000000 80777777
S 800 00000000 0000000F
W 0A0 00ABCDEF 00000000
R 0A0 00000000 00ABCDEF
W 0C5 00BEEF01 00000000
R 0C5 00000000 00BEEF01
S 800 00000000 00000007
W 0E1 7F654321 00000000
R 0E1 00000000 00654321
C 405 00000000 80123456
R 005 00000000 00123456
C 405 00000000 00123456
C 445 00000000 80777777
R 045 00000000 00777777
S 800 00000000 00000005
W 045 80000042 00000000
S 800 00000000 00000007
C 445 00000000 80000042
S 800 00000000 00000005
W 0C0 80C0FFEE 00000000
S 800 00000000 0000000D
W 0BF 80222222 00000000
F 800 00000005 00000000
S 800 00000000 00000008
R 03F 00000000 00FFFFFF
R 085 00000000 00555AAA
R 0BF 00000000 00222222
R 0C0 00000000 80C0FFEE
F C00 0000000F 00000000
S 800 00000000 00000008
F 800 00000000 00000000
S 800 00000000 00000008
F 800 00000008 00000000
S 800 00000000 00000000
R 0C0 00000000 00C0FFEE
W 105 80ABCDEF 00000000
R 105 00000000 00000000
R 005 00000000 00123456
S 800 00000000 00000000
W 3C5 80111111 00000000
R 3C5 00000000 00000000
R 0C5 00000000 00BEEF01
W 005 80FACADE 00000000
R 005 00000000 80FACADE
S 800 00000000 00000001
C 405 00000000 80FACADE
R 005 00000000 00FACADE
S 800 00000000 00000000

//--- tb_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tag_store
    import tag_store_pkg::*;
();

    localparam int    CLK_PERIOD       = 40;
    localparam int    NUM_BANKS        = 4;
    localparam string GOLDEN_FILE      = "tag_store_golden.txt";
    localparam int    SEED             = 32'hefa13a6e;
    // Ack latency in cycles after the accepting edge
    localparam int    WRITE_ACK_CYCLES = 1;
    localparam int    READ_ACK_CYCLES  = 3;

    logic     clk;
    logic     reset;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_we;
    wb_addr_t wb_adr;
    wb_data_t wb_dat_w;
    wb_data_t wb_dat_r;
    logic     wb_ack;

    // Transactions from the golden file
    byte      txn_op[$];
    wb_addr_t txn_adr[$];
    wb_data_t txn_dat[$];
    wb_data_t txn_exp[$];

    int ack_count = 0;
    bit load_done = 1'b0;

    tag_store_top i_dut (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Counts every ack pulse in mid cycle
    always @(negedge clk) begin
        if (wb_ack === 1'b1) begin
            ack_count <= ack_count + 1;
        end
    end

    ////////////////////////////////////////
    // Error handling and compare tasks
    ////////////////////////////////////////
    task automatic stop_run();
        $display("Testbench failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input wb_data_t got, input wb_data_t exp, input string name);
        if (got !== exp) begin
            $display("MISMATCH time=%0t ns signal=%s got=%h expected=%h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_status(input wb_data_t got, input wb_data_t exp);
        string occ_msg;
        if (got !== exp) begin
            occ_msg = $sformatf("occupancy got=%b expected=%b",
                                got[NUM_BANKS-1:0], exp[NUM_BANKS-1:0]);
            $display("MISMATCH time=%0t ns signal=wb_dat_r(status) got=%h expected=%h %s",
                     $time, got, exp, occ_msg);
            stop_run();
        end
    endtask

    task automatic check_ack(input logic got, input logic exp, input string phase);
        if (got !== exp) begin
            $display("MISMATCH time=%0t ns signal=wb_ack (%s) got=%b expected=%b",
                     $time, phase, got, exp);
            stop_run();
        end
    endtask

    task automatic check_latency(input int got, input int exp, input byte op);
        if (got != exp) begin
            $display("MISMATCH time=%0t ns signal=wb_ack latency (op %c) got=%0d expected=%0d",
                     $time, op, got, exp);
            stop_run();
        end
    endtask

    ////////////////////////////////////////
    // Golden file
    ////////////////////////////////////////
    task automatic load_golden();
        int       fd;
        int       code;
        int       fields;
        int       line_no;
        string    line;
        byte      op;
        wb_addr_t adr;
        wb_data_t dat;
        wb_data_t exp;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("ERROR: the golden file %s could not be opened", GOLDEN_FILE);
            stop_run();
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            line_no++;
            // Skip blank and column description lines
            if (code == 0 || line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            op     = line.getc(0);
            fields = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", adr, dat, exp);
            if (fields != 3) begin
                $display("ERROR: line %0d of the golden file has %0d fields", line_no, fields + 1);
                stop_run();
            end
            if (op != "W" && op != "R" && op != "C" && op != "F" && op != "S") begin
                $display("ERROR: line %0d of the golden file has an unknown operation", line_no);
                stop_run();
            end
            txn_op.push_back(op);
            txn_adr.push_back(adr);
            txn_dat.push_back(dat);
            txn_exp.push_back(exp);
        end
        $fclose(fd);
        if (txn_op.size() == 0) begin
            $display("ERROR: the golden file holds no transactions");
            stop_run();
        end
    endtask

    ////////////////////////////////////////
    // One Wishbone classic cycle
    ////////////////////////////////////////
    task automatic run_txn(input int idx);
        byte      op;
        logic     is_write;
        int       waited;
        wb_data_t got;
        op       = txn_op[idx];
        is_write = (op == "W") || (op == "F");
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= is_write;
        wb_adr   <= txn_adr[idx];
        wb_dat_w <= txn_dat[idx];
        // Held until the slave acks
        @(negedge clk);
        waited = 0;
        while (wb_ack !== 1'b1) begin
            @(negedge clk);
            waited++;
        end
        got = wb_dat_r;
        check_latency(waited, is_write ? WRITE_ACK_CYCLES : READ_ACK_CYCLES, op);
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        @(negedge clk);
        check_ack(wb_ack, 1'b0, "cycle after ack");
        case (op)
            "R", "C": check_word(got, txn_exp[idx], "wb_dat_r");
            "S":      check_status(got, txn_exp[idx]);
            default:  ;
        endcase
    endtask

    // Watchdog sized from the number of transactions
    initial begin
        int limit;
        wait (load_done);
        limit = txn_op.size() * (3 + 8) + 100;
        repeat (limit) @(posedge clk);
        $display("ERROR: timeout, the run did not finish within %0d cycles", limit);
        stop_run();
    end

    initial begin
        int gap;
        reset    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        void'($urandom(SEED));
        load_golden();
        load_done = 1'b1;

        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_ack(wb_ack, 1'b0, "after reset");

        for (int i = 0; i < txn_op.size(); i++) begin
            run_txn(i);
            gap = int'($urandom % 4);
            repeat (gap) begin
                @(negedge clk);
                check_ack(wb_ack, 1'b0, "idle");
            end
        end

        @(posedge clk);
        if (ack_count != txn_op.size()) begin
            $display("ERROR: %0d acks seen for %0d transactions", ack_count, txn_op.size());
            stop_run();
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- tag_store_top.sv
`timescale 1ns/1ps
`default_nettype none

module tag_store_top
    import tag_store_pkg::*;
#(
    parameter int NUM_BANKS = 4,
    parameter     RAM_TYPE  = "block"
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     wb_cyc,
    input  logic     wb_stb,
    input  logic     wb_we,
    input  wb_addr_t wb_adr,
    input  wb_data_t wb_dat_w,
    output wb_data_t wb_dat_r,
    output logic     wb_ack
);

    bank_req_t                  bank_req;
    logic      [NUM_BANKS-1:0]  bank_sel;
    logic      [NUM_BANKS-1:0]  flush_mask;
    logic      [NUM_BANKS-1:0]  occupancy;
    bank_rsp_t [NUM_BANKS-1:0]  bank_rsp;
    bank_idx_t                  rd_bank;
    logic                       rd_status;
    logic                       collect;

    wb_bank_decoder #(
        .NUM_BANKS (NUM_BANKS)
    ) i_decoder (
        .clk        (clk),
        .reset      (reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_ack     (wb_ack),
        .bank_req   (bank_req),
        .bank_sel   (bank_sel),
        .flush_mask (flush_mask),
        .rd_bank    (rd_bank),
        .rd_status  (rd_status),
        .collect    (collect)
    );

    ////////////////////////////////////////
    // Banks
    ////////////////////////////////////////
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        valid_tag_ram #(
            .RAM_TYPE (RAM_TYPE)
        ) i_bank (
            .clk      (clk),
            .reset    (reset),
            .req      (bank_req),
            .sel      (bank_sel[b]),
            .flush    (flush_mask[b]),
            .rsp      (bank_rsp[b]),
            .occupied (occupancy[b])
        );
    end

    bank_read_collector #(
        .NUM_BANKS (NUM_BANKS)
    ) i_collector (
        .clk       (clk),
        .reset     (reset),
        .bank_rsp  (bank_rsp),
        .occupancy (occupancy),
        .rd_bank   (rd_bank),
        .rd_status (rd_status),
        .collect   (collect),
        .wb_dat_r  (wb_dat_r)
    );

endmodule

`default_nettype wire

//--- bank_read_collector.sv
`timescale 1ns/1ps
`default_nettype none

module bank_read_collector
    import tag_store_pkg::*;
#(
    parameter int NUM_BANKS = 4
) (
    input  logic                            clk,
    input  logic                            reset,
    input  bank_rsp_t [NUM_BANKS-1:0]       bank_rsp,
    input  logic      [NUM_BANKS-1:0]       occupancy,
    input  bank_idx_t                       rd_bank,
    input  logic                            rd_status,
    input  logic                            collect,
    output wb_data_t                        wb_dat_r
);

    bank_rsp_t sel_rsp;
    wb_data_t  data_word;
    wb_data_t  status_word;

    // Bank mux gives zero when no bank matches
    always_comb begin
        sel_rsp = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (rd_bank == bank_idx_t'(i)) begin
                sel_rsp = bank_rsp[i];
            end
        end
    end

    ////////////////////////////////////////
    // Read word formats
    ////////////////////////////////////////
    always_comb begin
        data_word                       = '0;
        data_word[PAYLOAD_BITS-1:0]     = sel_rsp.payload;
        data_word[VALID_BIT]            = sel_rsp.valid;
    end

    // One occupancy flag per bank in the low bits
    always_comb begin
        status_word                 = '0;
        status_word[NUM_BANKS-1:0]  = occupancy;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_dat_r <= '0;
        end else if (collect) begin
            wb_dat_r <= rd_status ? status_word : data_word;
        end
    end

endmodule

`default_nettype wire

//--- wb_bank_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module wb_bank_decoder
    import tag_store_pkg::*;
#(
    parameter int NUM_BANKS = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  wb_addr_t             wb_adr,
    input  wb_data_t             wb_dat_w,
    output logic                 wb_ack,
    output bank_req_t            bank_req,
    output logic [NUM_BANKS-1:0] bank_sel,
    output logic [NUM_BANKS-1:0] flush_mask,
    output bank_idx_t            rd_bank,
    output logic                 rd_status,
    output logic                 collect
);

    dec_state_t  state;
    logic        accept;
    entry_addr_t wb_entry;
    bank_idx_t   wb_bank;
    logic        wb_consume;
    logic        wb_control;
    entry_addr_t entry_q;
    bank_idx_t   bank_q;
    logic        consume_q;
    logic        control_q;
    bank_idx_t   cur_bank;

    ////////////////////////////////////////
    // Address fields
    ////////////////////////////////////////
    assign wb_entry   = wb_adr[ENTRY_LSB +: ENTRY_ADDR_BITS];
    assign wb_bank    = wb_adr[BANK_LSB +: BANK_BITS];
    assign wb_consume = wb_adr[CONSUME_BIT];
    assign wb_control = wb_adr[CONTROL_BIT];

    // New transactions only in IDLE
    assign accept = (state == IDLE) && wb_cyc && wb_stb;

    ////////////////////////////////////////
    // FSM
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= wb_we ? ACK : READ_WAIT;
                    end
                end
                READ_WAIT:    state <= READ_COLLECT;
                READ_COLLECT: state <= ACK;
                default:      state <= IDLE;
            endcase
        end
    end

    // Transaction fields held for the read phases
    always_ff @(posedge clk) begin
        if (accept) begin
            entry_q   <= wb_entry;
            bank_q    <= wb_bank;
            consume_q <= wb_consume && !wb_control;
            control_q <= wb_control;
        end
    end

    // One-cycle flush pulse
    // A control write with CONSUME_BIT set flushes nothing
    always_ff @(posedge clk) begin
        if (reset) begin
            flush_mask <= '0;
        end else if (accept && wb_we && wb_control && !wb_consume) begin
            flush_mask <= wb_dat_w[NUM_BANKS-1:0];
        end else begin
            flush_mask <= '0;
        end
    end

    ////////////////////////////////////////
    // Bank request
    ////////////////////////////////////////

    // Writes go out in IDLE, reads one cycle later from the held fields
    always_comb begin
        bank_req               = '0;
        bank_req.addr          = (state == IDLE) ? wb_entry : entry_q;
        bank_req.payload       = wb_dat_w[PAYLOAD_BITS-1:0];
        bank_req.valid_tag     = wb_dat_w[VALID_BIT];
        bank_req.write_payload = accept && wb_we && !wb_control;
        bank_req.read_en       = (state == READ_WAIT) && !control_q;
        bank_req.clear_valid   = (state == READ_WAIT) && !control_q && consume_q;
    end

    // One-hot select; an out-of-range bank matches nothing
    assign cur_bank = (state == IDLE) ? wb_bank : bank_q;

    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            bank_sel[i] = (cur_bank == bank_idx_t'(i));
        end
    end

    assign rd_bank   = bank_q;
    assign rd_status = control_q;
    assign collect   = (state == READ_COLLECT);
    assign wb_ack    = (state == ACK);

endmodule

`default_nettype wire

//--- valid_tag_ram.sv
`timescale 1ns/1ps
`default_nettype none

module valid_tag_ram
    import tag_store_pkg::*;
#(
    parameter RAM_TYPE = "block"
) (
    input  logic      clk,
    input  logic      reset,
    input  bank_req_t req,
    input  logic      sel,
    input  logic      flush,
    output bank_rsp_t rsp,
    output logic      occupied
);

    logic [BANK_ENTRIES-1:0] valid_bits;
    logic                    valid_q;
    logic                    wr_en;
    logic                    rd_en;
    logic                    clr_en;
    payload_t                rd_payload;

    // Strobes only count for the selected bank
    assign wr_en  = sel && req.write_payload;
    assign rd_en  = sel && req.read_en;
    assign clr_en = sel && req.clear_valid;

    ////////////////////////////////////////
    // Valid bits
    ////////////////////////////////////////

    // Kept in flops so a flush clears all of them at once
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid_bits <= '0;
        end else if (wr_en) begin
            valid_bits[req.addr] <= req.valid_tag;
        end else if (clr_en) begin
            valid_bits[req.addr] <= 1'b0;
        end
    end

    // Tag read lines up with the payload read; old value seen on consume
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (rd_en) begin
            valid_q <= valid_bits[req.addr];
        end
    end

    assign occupied = |valid_bits;

    ////////////////////////////////////////
    // Payload storage
    ////////////////////////////////////////
    payload_ram #(
        .RAM_TYPE (RAM_TYPE)
    ) i_payload_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (req.addr),
        .wr_data (req.payload),
        .rd_en   (rd_en),
        .rd_addr (req.addr),
        .rd_data (rd_payload)
    );

    always_comb begin
        rsp         = '0;
        rsp.payload = rd_payload;
        rsp.valid   = valid_q;
    end

endmodule

`default_nettype wire

//--- payload_ram.sv
`timescale 1ns/1ps
`default_nettype none

module payload_ram
    import tag_store_pkg::*;
#(
    parameter RAM_TYPE = "block"
) (
    input  logic        clk,
    input  logic        wr_en,
    input  entry_addr_t wr_addr,
    input  payload_t    wr_data,
    input  logic        rd_en,
    input  entry_addr_t rd_addr,
    output payload_t    rd_data
);

    (* ram_style = RAM_TYPE *) payload_t mem [BANK_ENTRIES];

    // Write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read that holds between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- tag_store_pkg.sv
`default_nettype none

package tag_store_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////
    localparam int PAYLOAD_BITS    = 24;
    localparam int ENTRY_ADDR_BITS = 6;
    localparam int BANK_BITS       = 4;
    localparam int WB_ADDR_BITS    = 12;
    localparam int WB_DATA_BITS    = 32;
    localparam int BANK_ENTRIES    = 2 ** ENTRY_ADDR_BITS;

    typedef logic [PAYLOAD_BITS-1:0]    payload_t;
    typedef logic [ENTRY_ADDR_BITS-1:0] entry_addr_t;
    typedef logic [BANK_BITS-1:0]       bank_idx_t;
    typedef logic [WB_ADDR_BITS-1:0]    wb_addr_t;
    typedef logic [WB_DATA_BITS-1:0]    wb_data_t;

    ////////////////////////////////////////
    // Address map
    ////////////////////////////////////////
    localparam int ENTRY_LSB   = 0;
    localparam int BANK_LSB    = 6;
    localparam int CONSUME_BIT = 10;
    localparam int CONTROL_BIT = 11;
    // Valid tag position in the data word
    localparam int VALID_BIT   = 31;

    // Request broadcast to every bank
    typedef struct packed {
        logic        write_payload;
        entry_addr_t addr;
        payload_t    payload;
        logic        valid_tag;
        logic        clear_valid;
        logic        read_en;
    } bank_req_t;

    typedef struct packed {
        payload_t payload;
        logic     valid;
    } bank_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        READ_WAIT,
        READ_COLLECT,
        ACK
    } dec_state_t;

endpackage

`default_nettype wire
